// ==== src/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  rob_idx_t;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLL  = 3'd5,
    ALU_SRL  = 3'd6,
    ALU_ADDI = 3'd7
  } alu_op_t;

  // Instruction word layout
  localparam int OP_HI  = 31;
  localparam int OP_LO  = 29;
  localparam int RD_HI  = 28;
  localparam int RD_LO  = 24;
  localparam int RA_HI  = 23;
  localparam int RA_LO  = 19;
  localparam int RB_HI  = 18;
  localparam int RB_LO  = 14;
  localparam int IMM_HI = 13;
  localparam int IMM_LO = 0;

  typedef struct packed {
    alu_op_t  op;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    data_t    imm;
    data_t    pc;
  } dec_inst_t;

  typedef struct packed {
    dec_inst_t inst;
    rob_idx_t  slot;
  } iq_entry_t;

  typedef struct packed {
    alu_op_t  op;
    rob_idx_t slot;
    data_t    a;
    data_t    b;
  } ex_req_t;

  // Destination and pc handed to the ROB with a reservation
  typedef struct packed {
    reg_idx_t rd;
    data_t    pc;
  } rob_alloc_t;

  typedef struct packed {
    logic     valid;
    rob_idx_t slot;
    data_t    result;
  } rob_wr_t;

  typedef struct packed {
    logic  hit;
    logic  done;
    data_t value;
  } rob_lookup_t;

  typedef struct packed {
    logic     valid;
    data_t    pc;
    reg_idx_t rd;
    data_t    value;
  } retire_t;

endpackage

`default_nettype wire

// ==== src/ifetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifetch import pipe_pkg::*; (
  input  logic  clock,
  input  logic  rst_n,
  input  logic  stall,
  input  data_t cache_data,
  input  logic  cache_waitrequest,
  output data_t cache_addr,
  output logic  cache_rd,
  output data_t inst_word,
  output data_t inst_pc,
  output logic  inst_valid
);

  data_t pc_q;
  logic  read_done;

  // Request whenever the fetch register is empty or being drained
  assign cache_rd   = !inst_valid || !stall;
  assign cache_addr = pc_q;
  assign read_done  = cache_rd && !cache_waitrequest;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc_q       <= '0;
      inst_valid <= 1'b0;
    end else if (read_done) begin
      pc_q       <= pc_q + 32'd4;
      inst_valid <= 1'b1;
    end else if (!stall) begin
      inst_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (read_done) begin
      inst_word <= cache_data;
      inst_pc   <= pc_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode import pipe_pkg::*; (
  input  data_t      inst_word,
  input  data_t      inst_pc,
  input  logic       inst_valid,
  input  logic       iq_full,
  input  logic       rob_full,
  input  rob_idx_t   rob_tail,
  output logic       stall,
  output logic       push,
  output iq_entry_t  entry,
  output logic       reserve,
  output rob_alloc_t dest
);

  localparam int IMM_W = IMM_HI - IMM_LO + 1;

  dec_inst_t dec;

  always_comb begin
    dec.op  = alu_op_t'(inst_word[OP_HI:OP_LO]);
    dec.rd  = inst_word[RD_HI:RD_LO];
    dec.ra  = inst_word[RA_HI:RA_LO];
    dec.rb  = inst_word[RB_HI:RB_LO];
    // 14-bit signed immediate
    dec.imm = {{(32 - IMM_W){inst_word[IMM_HI]}}, inst_word[IMM_HI:IMM_LO]};
    dec.pc  = inst_pc;
  end

  // Hold the word until both the queue and the ROB have room
  assign stall   = inst_valid && (iq_full || rob_full);
  assign push    = inst_valid && !stall;
  assign reserve = push;

  assign entry.inst = dec;
  assign entry.slot = rob_tail;
  assign dest.rd    = dec.rd;
  assign dest.pc    = dec.pc;

endmodule

`default_nettype wire

// ==== src/circ_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

module circ_buf import pipe_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic      clock,
  input  logic      rst_n,
  input  logic      push,
  input  iq_entry_t new_entry,
  input  logic      pop,
  output iq_entry_t head,
  output logic      not_empty,
  output logic      full
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] CAP = (AW + 1)'(DEPTH);

  iq_entry_t     mem [DEPTH];
  logic [AW-1:0] head_q;
  logic [AW-1:0] tail_q;
  logic [AW:0]   count_q;

  assign head      = mem[head_q];
  assign not_empty = (count_q != '0);
  assign full      = (count_q == CAP);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push)
        tail_q <= tail_q + 1'b1;
      if (pop)
        head_q <= head_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push)
      mem[tail_q] <= new_entry;
  end

endmodule

`default_nettype wire

// ==== src/issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue import pipe_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  iq_entry_t   head,
  input  logic        not_empty,
  input  rob_lookup_t look_a,
  input  rob_lookup_t look_b,
  input  data_t       rd_data_a,
  input  data_t       rd_data_b,
  output logic        pop,
  output reg_idx_t    src_a,
  output reg_idx_t    src_b,
  output rob_idx_t    query_slot,
  output ex_req_t     req,
  output logic        req_valid
);

  logic  is_imm;
  logic  ready_a;
  logic  ready_b;
  data_t opnd_a;
  data_t opnd_b;

  assign src_a      = head.inst.ra;
  assign src_b      = head.inst.rb;
  assign query_slot = head.slot;

  assign is_imm = (head.inst.op == ALU_ADDI);

  // A pending producer blocks until its result is in the ROB
  assign ready_a = !look_a.hit || look_a.done;
  assign ready_b = is_imm || !look_b.hit || look_b.done;

  assign opnd_a = look_a.hit ? look_a.value : rd_data_a;

  always_comb begin
    if (is_imm)
      opnd_b = head.inst.imm;
    else if (look_b.hit)
      opnd_b = look_b.value;
    else
      opnd_b = rd_data_b;
  end

  assign pop = not_empty && ready_a && ready_b;

  always_ff @(posedge clock) begin
    if (!rst_n)
      req_valid <= 1'b0;
    else
      req_valid <= pop;
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      req.op   <= head.inst.op;
      req.slot <= head.slot;
      req.a    <= opnd_a;
      req.b    <= opnd_b;
    end
  end

endmodule

`default_nettype wire

// ==== src/ex_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_alu import pipe_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,
  input  ex_req_t req,
  input  logic    req_valid,
  output rob_wr_t wr
);

  data_t result;

  always_comb begin
    case (req.op)
      ALU_ADD:  result = req.a + req.b;
      ALU_SUB:  result = req.a - req.b;
      ALU_AND:  result = req.a & req.b;
      ALU_OR:   result = req.a | req.b;
      ALU_XOR:  result = req.a ^ req.b;
      // Shift amount is b mod 32
      ALU_SLL:  result = req.a << req.b[4:0];
      ALU_SRL:  result = req.a >> req.b[4:0];
      default:  result = req.a + req.b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n)
      wr.valid <= 1'b0;
    else
      wr.valid <= req_valid;
  end

  always_ff @(posedge clock) begin
    wr.slot   <= req.slot;
    wr.result <= result;
  end

endmodule

`default_nettype wire

// ==== src/rob.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob import pipe_pkg::*; #(
  parameter int DEPTH = 16
) (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        reserve,
  input  rob_alloc_t  dest,
  input  reg_idx_t    src_a,
  input  reg_idx_t    src_b,
  input  rob_idx_t    query_slot,
  input  rob_wr_t     wr,
  output rob_idx_t    tail,
  output logic        full,
  output rob_lookup_t look_a,
  output rob_lookup_t look_b,
  output logic        rf_we,
  output reg_idx_t    rf_addr,
  output data_t       rf_data,
  output retire_t     retire
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] CAP = (AW + 1)'(DEPTH);

  reg_idx_t         rd_q  [DEPTH];
  data_t            pc_q  [DEPTH];
  data_t            res_q [DEPTH];
  logic [DEPTH-1:0] done_q;
  logic [AW-1:0]    head_q;
  logic [AW-1:0]    tail_q;
  logic [AW:0]      count_q;
  logic [AW-1:0]    span;
  logic             retiring;
  retire_t          retire_q;

  // Youngest older writer of src wins since later slots overwrite the result
  function automatic rob_lookup_t search(input reg_idx_t src);
    rob_lookup_t   res;
    logic [AW-1:0] pos;
    res = '0;
    for (int k = 0; k < DEPTH; k++) begin
      pos = head_q + AW'(k);
      if (AW'(k) < span && src != '0 && rd_q[pos] == src) begin
        res.hit   = 1'b1;
        res.done  = done_q[pos];
        res.value = res_q[pos];
      end
    end
    return res;
  endfunction

  assign tail = rob_idx_t'(tail_q);
  assign full = (count_q == CAP);

  // Number of entries older than the querying slot
  assign span = query_slot[AW-1:0] - head_q;

  always_comb begin
    look_a = search(src_a);
    look_b = search(src_b);
  end

  assign retiring = (count_q != '0) && done_q[head_q];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
      done_q   <= '0;
      retire_q <= '0;
    end else begin
      if (reserve) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (wr.valid)
        done_q[wr.slot[AW-1:0]] <= 1'b1;
      if (retiring)
        head_q <= head_q + 1'b1;
      case ({reserve, retiring})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      retire_q.valid <= retiring;
      retire_q.pc    <= pc_q[head_q];
      retire_q.rd    <= rd_q[head_q];
      retire_q.value <= res_q[head_q];
    end
  end

  always_ff @(posedge clock) begin
    if (reserve) begin
      rd_q[tail_q] <= dest.rd;
      pc_q[tail_q] <= dest.pc;
    end
    if (wr.valid)
      res_q[wr.slot[AW-1:0]] <= wr.result;
  end

  // Register file write port and retire output share one register
  assign rf_we   = retire_q.valid;
  assign rf_addr = retire_q.rd;
  assign rf_data = retire_q.value;
  assign retire  = retire_q;

endmodule

`default_nettype wire

// ==== src/rfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rfile import pipe_pkg::*; (
  input  logic     clock,
  input  logic     rst_n,
  input  reg_idx_t rd_addr_a,
  input  reg_idx_t rd_addr_b,
  input  logic     wr_enable,
  input  reg_idx_t wr_addr,
  input  data_t    wr_data,
  output data_t    rd_data_a,
  output data_t    rd_data_b
);

  data_t regs [32];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wr_enable && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write-through covers the cycle the entry leaves the ROB
  assign rd_data_a = (rd_addr_a == '0) ? '0 :
                     (wr_enable && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 :
                     (wr_enable && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== src/pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline import pipe_pkg::*; #(
  parameter int IQ_DEPTH  = 8,
  parameter int ROB_DEPTH = 16
) (
  input  logic    clock,
  input  logic    rst_n,
  input  data_t   icache_data,
  input  logic    icache_waitrequest,
  output data_t   icache_addr,
  output logic    icache_rd,
  output retire_t retire
);

  // Fetch
  data_t       if_word;
  data_t       if_pc;
  logic        if_valid;

  // Decode
  logic        id_stall;
  logic        id_push;
  iq_entry_t   id_entry;
  logic        id_reserve;
  rob_alloc_t  id_dest;

  // Issue queue and issue
  iq_entry_t   iq_head;
  logic        iq_not_empty;
  logic        iq_full;
  logic        iss_pop;
  reg_idx_t    iss_src_a;
  reg_idx_t    iss_src_b;
  rob_idx_t    iss_slot;
  ex_req_t     iss_req;
  logic        iss_req_valid;

  // ALU, ROB, register file
  rob_wr_t     alu_wr;
  rob_idx_t    rob_tail;
  logic        rob_full;
  rob_lookup_t rob_look_a;
  rob_lookup_t rob_look_b;
  logic        rf_we;
  reg_idx_t    rf_addr;
  data_t       rf_data;
  data_t       rf_rd_a;
  data_t       rf_rd_b;

  ifetch fetch_i (
    .clock             (clock),
    .rst_n             (rst_n),
    .stall             (id_stall),
    .cache_data        (icache_data),
    .cache_waitrequest (icache_waitrequest),
    .cache_addr        (icache_addr),
    .cache_rd          (icache_rd),
    .inst_word         (if_word),
    .inst_pc           (if_pc),
    .inst_valid        (if_valid)
  );

  decode dec_i (
    .inst_word  (if_word),
    .inst_pc    (if_pc),
    .inst_valid (if_valid),
    .iq_full    (iq_full),
    .rob_full   (rob_full),
    .rob_tail   (rob_tail),
    .stall      (id_stall),
    .push       (id_push),
    .entry      (id_entry),
    .reserve    (id_reserve),
    .dest       (id_dest)
  );

  circ_buf #(
    .DEPTH (IQ_DEPTH)
  ) iq_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .push      (id_push),
    .new_entry (id_entry),
    .pop       (iss_pop),
    .head      (iq_head),
    .not_empty (iq_not_empty),
    .full      (iq_full)
  );

  issue iss_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .head       (iq_head),
    .not_empty  (iq_not_empty),
    .look_a     (rob_look_a),
    .look_b     (rob_look_b),
    .rd_data_a  (rf_rd_a),
    .rd_data_b  (rf_rd_b),
    .pop        (iss_pop),
    .src_a      (iss_src_a),
    .src_b      (iss_src_b),
    .query_slot (iss_slot),
    .req        (iss_req),
    .req_valid  (iss_req_valid)
  );

  ex_alu alu_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .req       (iss_req),
    .req_valid (iss_req_valid),
    .wr        (alu_wr)
  );

  rob #(
    .DEPTH (ROB_DEPTH)
  ) rob_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .reserve    (id_reserve),
    .dest       (id_dest),
    .src_a      (iss_src_a),
    .src_b      (iss_src_b),
    .query_slot (iss_slot),
    .wr         (alu_wr),
    .tail       (rob_tail),
    .full       (rob_full),
    .look_a     (rob_look_a),
    .look_b     (rob_look_b),
    .rf_we      (rf_we),
    .rf_addr    (rf_addr),
    .rf_data    (rf_data),
    .retire     (retire)
  );

  rfile rf_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .rd_addr_a (iss_src_a),
    .rd_addr_b (iss_src_b),
    .wr_enable (rf_we),
    .wr_addr   (rf_addr),
    .wr_data   (rf_data),
    .rd_data_a (rf_rd_a),
    .rd_data_b (rf_rd_b)
  );

endmodule

`default_nettype wire

// ==== bench/pipeline_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline_tb import pipe_pkg::*; ();

  localparam int IQ_DEPTH   = 8;
  localparam int ROB_DEPTH  = 16;
  localparam int MEM_WORDS  = 512;
  localparam int NUM_RETIRE = 400;
  localparam int IDLE_LIMIT = 500;

  logic    clock;
  logic    rst_n;
  data_t   icache_data;
  logic    icache_waitrequest;
  data_t   icache_addr;
  logic    icache_rd;
  retire_t retire;

  integer  seed;
  data_t   imem [MEM_WORDS];
  data_t   arch_regs [32];
  int      fetched;
  int      retired;
  int      idle;

  pipeline #(
    .IQ_DEPTH  (IQ_DEPTH),
    .ROB_DEPTH (ROB_DEPTH)
  ) dut_i (
    .clock              (clock),
    .rst_n              (rst_n),
    .icache_data        (icache_data),
    .icache_waitrequest (icache_waitrequest),
    .icache_addr        (icache_addr),
    .icache_rd          (icache_rd),
    .retire             (retire)
  );

  always #4 clock = ~clock;

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is r%0d, expected r%0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // About half of the register fields land in r0..r3
  task automatic random_reg(output reg_idx_t idx);
    logic [31:0] r;
    r = $random(seed);
    if (r[5])
      idx = {3'b000, r[1:0]};
    else
      idx = r[4:0];
  endtask

  task automatic fill_memory();
    logic [31:0] r;
    reg_idx_t    rd;
    reg_idx_t    ra;
    reg_idx_t    rb;
    for (int i = 0; i < MEM_WORDS; i++) begin
      r = $random(seed);
      random_reg(rd);
      random_reg(ra);
      random_reg(rb);
      imem[i] = {r[18:16], rd, ra, rb, r[13:0]};
    end
  endtask

  // Architectural result of one instruction word
  function automatic data_t model_result(input data_t word);
    data_t a;
    data_t b;
    data_t imm;
    a   = arch_regs[word[23:19]];
    b   = arch_regs[word[18:14]];
    imm = {{18{word[13]}}, word[13:0]};
    case (word[31:29])
      3'd0:    return a + b;
      3'd1:    return a - b;
      3'd2:    return a & b;
      3'd3:    return a | b;
      3'd4:    return a ^ b;
      3'd5:    return a << b[4:0];
      3'd6:    return a >> b[4:0];
      default: return a + imm;
    endcase
  endfunction

  // Cache inputs stay fixed from here to the next rising edge
  task automatic drive_cache();
    logic [31:0] r;
    r = $random(seed);
    icache_waitrequest = (r[1:0] == 2'b00);
    icache_data        = imem[icache_addr[10:2]];
    if (icache_rd) begin
      // Requested address must be the next unread word
      check_word("icache_addr", icache_addr, data_t'(fetched * 4));
      if (!icache_waitrequest)
        fetched++;
    end
  endtask

  task automatic score_retirement();
    data_t    word;
    data_t    exp_value;
    reg_idx_t exp_rd;
    if (retire.valid === 1'b1) begin
      word      = imem[retired % MEM_WORDS];
      exp_rd    = word[28:24];
      exp_value = model_result(word);
      check_word("retire.pc", retire.pc, data_t'(retired * 4));
      check_reg("retire.rd", retire.rd, exp_rd);
      check_word("retire.value", retire.value, exp_value);
      if (exp_rd != 5'd0)
        arch_regs[exp_rd] = exp_value;
      retired++;
      idle = 0;
    end else begin
      idle++;
    end
  endtask

  initial begin
    seed               = 56268;
    clock              = 1'b0;
    rst_n              = 1'b0;
    icache_data        = '0;
    icache_waitrequest = 1'b0;
    fetched            = 0;
    retired            = 0;
    idle               = 0;
    for (int i = 0; i < 32; i++)
      arch_regs[i] = '0;
    fill_memory();

    repeat (2) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;

    // State right after reset
    check_flag("retire.valid", retire.valid, 1'b0);
    check_flag("icache_rd", icache_rd, 1'b1);
    check_word("icache_addr", icache_addr, 32'd0);
    drive_cache();

    while (retired < NUM_RETIRE && idle < IDLE_LIMIT) begin
      @(negedge clock);
      score_retirement();
      drive_cache();
    end

    if (retired == NUM_RETIRE) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Timeout: no retirement in %0d cycles after %0d retired", IDLE_LIMIT, retired);
      stop_run();
    end
  end

endmodule

`default_nettype wire

// ==== pipeline.f ====
src/pipe_pkg.sv
src/ifetch.sv
src/decode.sv
src/circ_buf.sv
src/issue.sv
src/ex_alu.sv
src/rob.sv
src/rfile.sv
src/pipeline.sv
bench/pipeline_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module pipeline_tb -f pipeline.f \
  -o pipeline_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/pipeline_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
